// ==== Makefile ====
TOP = tb_mem_wb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f mem_wb.f --top-module $(TOP)

obj_dir/V$(TOP): $(wildcard *.sv *.svh) mem_wb.f
	verilator --binary --timing --assert -j 0 -f mem_wb.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== cache_access_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_access_unit (
   input  wire logic                clk_i,
   input  wire logic                valid_i,
   input  wire logic [1:0]          addr_align_i,
   input  wire logic [31:0]         core_raw_data_i,
   input  wire logic [31:0]         cache_raw_data_i,
   input  wire mem_wb_pkg::lsu_op_e op_type_i,
   output logic [3:0]               write_en_o,
   output logic [31:0]              core_normalized_data_o,
   output logic [31:0]              cache_normalized_data_o
);
   import mem_wb_pkg::*;

   mem_wb_pkg::mem_word_u st_word;
   mem_wb_pkg::mem_word_u ld_word;

   ////////////////////////////////////////////////////////////////////////////
   // Store path
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      st_word    = '0;
      write_en_o = 4'b0000;
      case (op_type_i)
         OP_SB: begin
            st_word.bytes[addr_align_i] = core_raw_data_i[7:0];
            write_en_o = 4'b0001 << addr_align_i;
         end
         OP_SH: begin
            st_word.halves[addr_align_i[1]] = core_raw_data_i[15:0];
            write_en_o = addr_align_i[1] ? 4'b1100 : 4'b0011;
         end
         OP_SW: begin
            st_word    = mem_word_u'(core_raw_data_i);
            write_en_o = 4'b1111;
         end
         default: begin
            // Loads and non-memory ops write nothing
            write_en_o = 4'b0000;
         end
      endcase
   end

   assign core_normalized_data_o = st_word;

   ////////////////////////////////////////////////////////////////////////////
   // Load path
   ////////////////////////////////////////////////////////////////////////////

   assign ld_word = mem_word_u'(cache_raw_data_i);

   always_comb begin
      case (op_type_i)
         OP_LB: begin
            cache_normalized_data_o = {{24{ld_word.bytes[addr_align_i][7]}},
                                       ld_word.bytes[addr_align_i]};
         end
         OP_LBU: begin
            cache_normalized_data_o = {24'd0, ld_word.bytes[addr_align_i]};
         end
         OP_LH: begin
            cache_normalized_data_o = {{16{ld_word.halves[addr_align_i[1]][15]}},
                                       ld_word.halves[addr_align_i[1]]};
         end
         OP_LHU: begin
            cache_normalized_data_o = {16'd0, ld_word.halves[addr_align_i[1]]};
         end
         default: begin
            cache_normalized_data_o = ld_word;
         end
      endcase
   end

   // Misaligned accesses are not supported by the lane logic above
   a_half_aligned : assert property (@(posedge clk_i)
      valid_i && (op_type_i inside {OP_LH, OP_LHU, OP_SH}) |-> !addr_align_i[0])
      else $error("misaligned halfword access, offset %0d", addr_align_i);

   a_word_aligned : assert property (@(posedge clk_i)
      valid_i && (op_type_i inside {OP_LW, OP_SW}) |-> addr_align_i == 2'b00)
      else $error("misaligned word access, offset %0d", addr_align_i);

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mem_wb_defines.svh"

module data_ram (
   input  wire logic clk_i,
   input  wire logic rst_i,
   wb_if.slave       wb
);

   logic [31:0]               mem [`MEM_WB_RAM_WORDS];
   logic [`MEM_WB_RAM_AW-1:0] word_idx;
   logic                      ack_q;
   logic [31:0]               rd_data_q;
   logic                      req;

   // Upper address bits fall outside the array and are dropped
   assign word_idx = wb.adr[`MEM_WB_RAM_AW-1:0];

   // New request only when not already acknowledging
   assign req = wb.cyc && wb.stb && !ack_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (req && wb.we) begin
         for (int i = 0; i < 4; i++) begin
            if (wb.sel[i]) begin
               mem[word_idx][8*i +: 8] <= wb.dat_m2s[8*i +: 8];
            end
         end
      end
      rd_data_q <= mem[word_idx];
   end

   assign wb.ack     = ack_q;
   assign wb.dat_s2m = rd_data_q;

   // Ack only inside a bus cycle the master still holds
   a_ack_in_cyc : assert property (@(posedge clk_i) disable iff (rst_i)
      wb.ack |-> wb.cyc && wb.stb)
      else $error("ack raised without stb");

endmodule

`default_nettype wire

// ==== mem_wb.f ====
+incdir+.
mem_wb_pkg.sv
wb_if.sv
mw_if.sv
cache_access_unit.sv
memory_stage.sv
data_ram.sv
writeback_stage.sv
mem_wb_top.sv
tb_mem_wb.sv

// ==== mem_wb_defines.svh ====
`ifndef MEM_WB_DEFINES_SVH
`define MEM_WB_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Data RAM geometry
////////////////////////////////////////////////////////////////////////////

// Number of 32-bit words in the data RAM
`define MEM_WB_RAM_WORDS 256

// Word address width, log2 of the depth
`define MEM_WB_RAM_AW 8

// Keep the two values in step when resizing the RAM
// 512 words would need an address width of 9

`endif

// ==== mem_wb_pkg.sv ====
`default_nettype none

package mem_wb_pkg;

   /////////////////////////////////////////////////////////////////////////
   // Load/store operation
   /////////////////////////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      OP_NONE = 4'd0,
      OP_LB   = 4'd1,
      OP_LH   = 4'd2,
      OP_LW   = 4'd3,
      OP_LBU  = 4'd4,
      OP_LHU  = 4'd5,
      OP_SB   = 4'd6,
      OP_SH   = 4'd7,
      OP_SW   = 4'd8
   } lsu_op_e;

   /////////////////////////////////////////////////////////////////////////
   // Writeback source select
   /////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      WB_ALU  = 2'd0,
      WB_LOAD = 2'd1,
      WB_PC4  = 2'd2,
      WB_IMM  = 2'd3
   } wb_sel_e;

   /////////////////////////////////////////////////////////////////////////
   // RAM data word
   /////////////////////////////////////////////////////////////////////////

   // Same 32 bits seen as byte lanes or halfword lanes
   typedef union packed {
      logic [3:0][7:0]  bytes;
      logic [1:0][15:0] halves;
   } mem_word_u;

endpackage

`default_nettype wire

// ==== mem_wb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_wb_top (
   input  wire logic                clk_i,
   input  wire logic                rst_i,
   input  wire logic                in_valid_i,
   output logic                     in_ready_o,
   input  wire mem_wb_pkg::lsu_op_e op_type_i,
   input  wire logic                reg_wb_en_i,
   input  wire logic [4:0]          rd_label_i,
   input  wire logic [31:0]         alu_out_i,
   input  wire mem_wb_pkg::wb_sel_e wb_sel_i,
   input  wire logic [31:0]         imm_i,
   input  wire logic [31:0]         pc_i,
   input  wire logic [31:0]         rs2_data_i,
   output logic                     rf_we_o,
   output logic [4:0]               rf_addr_o,
   output logic [31:0]              rf_data_o
);

   // Memory stage to data RAM
   wb_if wb_bus ();

   // Memory stage to writeback
   mw_if mw_bus ();

   memory_stage u_memory_stage (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .op_type_i   (op_type_i),
      .reg_wb_en_i (reg_wb_en_i),
      .rd_label_i  (rd_label_i),
      .alu_out_i   (alu_out_i),
      .wb_sel_i    (wb_sel_i),
      .imm_i       (imm_i),
      .pc_i        (pc_i),
      .rs2_data_i  (rs2_data_i),
      .wb          (wb_bus.master),
      .mw          (mw_bus.source)
   );

   data_ram u_data_ram (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .wb    (wb_bus.slave)
   );

   writeback_stage u_writeback_stage (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .mw        (mw_bus.sink),
      .rf_we_o   (rf_we_o),
      .rf_addr_o (rf_addr_o),
      .rf_data_o (rf_data_o)
   );

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
   input  wire logic                clk_i,
   input  wire logic                rst_i,
   input  wire logic                in_valid_i,
   output logic                     in_ready_o,
   input  wire mem_wb_pkg::lsu_op_e op_type_i,
   input  wire logic                reg_wb_en_i,
   input  wire logic [4:0]          rd_label_i,
   input  wire logic [31:0]         alu_out_i,
   input  wire mem_wb_pkg::wb_sel_e wb_sel_i,
   input  wire logic [31:0]         imm_i,
   input  wire logic [31:0]         pc_i,
   input  wire logic [31:0]         rs2_data_i,
   wb_if.master                     wb,
   mw_if.source                     mw
);
   import mem_wb_pkg::*;

   // Registered instruction fields
   lsu_op_e     op_q;
   logic        reg_wb_en_q;
   logic [4:0]  rd_q;
   logic [31:0] alu_q;
   wb_sel_e     wb_sel_q;
   logic [31:0] imm_q;
   logic [31:0] pc_q;
   logic [31:0] rs2_q;

   // Control state
   logic        req_q;
   logic        cyc_q;
   logic        out_valid_q;
   logic [31:0] load_val_q;

   logic        accept;
   logic        is_store;
   logic [3:0]  write_en;
   logic [31:0] store_data;
   logic [31:0] load_data;

   // Stall while a bus cycle is waiting or running
   assign in_ready_o = !(req_q || cyc_q);
   assign accept     = in_valid_i && in_ready_o;
   assign is_store   = op_q inside {OP_SB, OP_SH, OP_SW};

   always_ff @(posedge clk_i) begin
      if (accept) begin
         op_q        <= op_type_i;
         reg_wb_en_q <= reg_wb_en_i;
         rd_q        <= rd_label_i;
         alu_q       <= alu_out_i;
         wb_sel_q    <= wb_sel_i;
         imm_q       <= imm_i;
         pc_q        <= pc_i;
         rs2_q       <= rs2_data_i;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus sequencing
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         req_q       <= 1'b0;
         cyc_q       <= 1'b0;
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= 1'b0;
         if (accept) begin
            if (op_type_i == OP_NONE) begin
               out_valid_q <= 1'b1;
            end else begin
               req_q <= 1'b1;
            end
         end
         // Issue one edge after acceptance
         if (req_q) begin
            req_q <= 1'b0;
            cyc_q <= 1'b1;
         end
         if (cyc_q && wb.ack) begin
            cyc_q       <= 1'b0;
            out_valid_q <= 1'b1;
         end
      end
   end

   // Load value sampled on the acknowledge
   always_ff @(posedge clk_i) begin
      if (cyc_q && wb.ack) begin
         load_val_q <= load_data;
      end
   end

   cache_access_unit u_cau (
      .clk_i                   (clk_i),
      .valid_i                 (cyc_q),
      .addr_align_i            (alu_q[1:0]),
      .core_raw_data_i         (rs2_q),
      .cache_raw_data_i        (wb.dat_s2m),
      .op_type_i               (op_q),
      .write_en_o              (write_en),
      .core_normalized_data_o  (store_data),
      .cache_normalized_data_o (load_data)
   );

   assign wb.cyc     = cyc_q;
   assign wb.stb     = cyc_q;
   assign wb.we      = is_store;
   assign wb.adr     = alu_q[31:2];
   assign wb.sel     = is_store ? write_en : 4'b1111;
   assign wb.dat_m2s = store_data;

   ////////////////////////////////////////////////////////////////////////////
   // Writeback hand-off
   ////////////////////////////////////////////////////////////////////////////

   assign mw.valid     = out_valid_q;
   assign mw.reg_wb_en = reg_wb_en_q;
   assign mw.rd_label  = rd_q;
   assign mw.wb_sel    = wb_sel_q;
   assign mw.alu_out   = alu_q;
   assign mw.imm       = imm_q;
   assign mw.pc        = pc_q;
   assign mw.load_val  = load_val_q;

   // Slave answers one cycle after it samples stb
   a_ack_timing : assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(wb.stb) |=> wb.ack)
      else $error("no ack one cycle after stb was raised");

   // Classic handshake, master holds everything until ack
   a_master_hold : assert property (@(posedge clk_i) disable iff (rst_i)
      wb.stb && !wb.ack |=> wb.cyc && wb.stb &&
         $stable({wb.we, wb.adr, wb.sel, wb.dat_m2s}))
      else $error("master signals changed before ack");

endmodule

`default_nettype wire

// ==== mw_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Memory stage to writeback stage bundle, sink always accepts
interface mw_if;
   import mem_wb_pkg::*;

   logic        valid;
   logic        reg_wb_en;
   logic [4:0]  rd_label;
   wb_sel_e     wb_sel;
   logic [31:0] alu_out;
   logic [31:0] imm;
   logic [31:0] pc;
   logic [31:0] load_val;

   modport source (
      output valid, reg_wb_en, rd_label, wb_sel,
      output alu_out, imm, pc, load_val
   );

   modport sink (
      input valid, reg_wb_en, rd_label, wb_sel,
      input alu_out, imm, pc, load_val
   );

endinterface

`default_nettype wire

// ==== tb_mem_wb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mem_wb_defines.svh"

module tb_mem_wb;
   import mem_wb_pkg::*;

   localparam int N_FILL     = `MEM_WB_RAM_WORDS;
   localparam int N_SELECT   = 60;
   localparam int N_PAIRS    = 80;
   localparam int N_LOAD     = 120;
   localparam int N_QUIET    = 40;
   localparam int N_MIXED    = 300;
   localparam int N_TOTAL    = N_FILL + N_SELECT + 2 * N_PAIRS + N_LOAD + N_QUIET + N_MIXED;
   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 8;

   logic        clk_i = 1'b0;
   logic        rst_i;
   logic        in_valid_i;
   logic        in_ready_o;
   lsu_op_e     op_type_i;
   logic        reg_wb_en_i;
   logic [4:0]  rd_label_i;
   logic [31:0] alu_out_i;
   wb_sel_e     wb_sel_i;
   logic [31:0] imm_i;
   logic [31:0] pc_i;
   logic [31:0] rs2_data_i;
   logic        rf_we_o;
   logic [4:0]  rf_addr_o;
   logic [31:0] rf_data_o;

   integer      seed = 32'h4371;
   logic [31:0] model_ram [`MEM_WB_RAM_WORDS];
   logic [4:0]  exp_rd_q [$];
   logic [31:0] exp_data_q [$];
   string       exp_name_q [$];
   string       test_name;

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   mem_wb_top mem_wb_top_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .op_type_i   (op_type_i),
      .reg_wb_en_i (reg_wb_en_i),
      .rd_label_i  (rd_label_i),
      .alu_out_i   (alu_out_i),
      .wb_sel_i    (wb_sel_i),
      .imm_i       (imm_i),
      .pc_i        (pc_i),
      .rs2_data_i  (rs2_data_i),
      .rf_we_o     (rf_we_o),
      .rf_addr_o   (rf_addr_o),
      .rf_data_o   (rf_data_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   // RISC-V load rules on a little-endian word
   function automatic logic [31:0] load_expect(input lsu_op_e op, input logic [31:0] word,
                                               input logic [1:0] off);
      logic [7:0]  b;
      logic [15:0] h;
      b = word[8*off +: 8];
      h = off[1] ? word[31:16] : word[15:0];
      case (op)
         OP_LB:   return {{24{b[7]}}, b};
         OP_LBU:  return {24'h0, b};
         OP_LH:   return {{16{h[15]}}, h};
         OP_LHU:  return {16'h0, h};
         default: return word;
      endcase
   endfunction

   // Keep the address inside the RAM, aligned to the access size
   function automatic logic [31:0] aligned_addr(input lsu_op_e op, input logic [31:0] r);
      logic [31:0] a;
      a = r & ((`MEM_WB_RAM_WORDS * 4) - 1);
      if (op inside {OP_LH, OP_LHU, OP_SH}) begin
         a[0] = 1'b0;
      end else if (op inside {OP_LW, OP_SW}) begin
         a[1:0] = 2'b00;
      end
      return a;
   endfunction

   function automatic lsu_op_e pick_load(input int k);
      case (k)
         0:       return OP_LB;
         1:       return OP_LH;
         2:       return OP_LW;
         3:       return OP_LBU;
         default: return OP_LHU;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_addr(input string name, input logic [4:0] exp_val,
                             input logic [4:0] act_val);
      if (act_val !== exp_val) begin
         $display("MISMATCH %s rd: expected x%0d, actual x%0d", name, exp_val, act_val);
         $display("** FAIL **");
         $fatal(1, "register address check failed");
      end
   endtask

   task automatic check_data(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
      if (act_val !== exp_val) begin
         $display("MISMATCH %s data: expected %08h, actual %08h", name, exp_val, act_val);
         $display("** FAIL **");
         $fatal(1, "register data check failed");
      end
   endtask

   // Register writes sampled mid-cycle, one write per cycle of rf_we_o
   always @(negedge clk_i) begin : monitor
      string       nm;
      logic [4:0]  rd;
      logic [31:0] data;
      if (!rst_i && rf_we_o === 1'b1) begin
         if (exp_rd_q.size() == 0) begin
            $display("Register write to x%0d with no instruction that should write",
                     rf_addr_o);
            $display("** FAIL **");
            $fatal(1, "unexpected register write");
         end else begin
            nm   = exp_name_q.pop_front();
            rd   = exp_rd_q.pop_front();
            data = exp_data_q.pop_front();
            check_addr(nm, rd, rf_addr_o);
            check_data(nm, data, rf_data_o);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic idle_cycle();
      @(negedge clk_i);
      in_valid_i = 1'b0;
   endtask

   task automatic maybe_idle();
      if (($random(seed) & 3) == 0) begin
         idle_cycle();
      end
   endtask

   // Present one instruction; it is taken on the next rising edge
   task automatic send(input lsu_op_e op, input logic wb_en, input logic [4:0] rd,
                       input logic [31:0] alu, input wb_sel_e sel, input logic [31:0] imm,
                       input logic [31:0] pc, input logic [31:0] rs2);
      logic [`MEM_WB_RAM_AW-1:0] idx;
      logic [1:0]                off;
      logic [31:0]               load_val;
      logic [31:0]               result;
      idx = alu[`MEM_WB_RAM_AW+1:2];
      off = alu[1:0];
      @(negedge clk_i);
      in_valid_i = 1'b0;
      while (in_ready_o !== 1'b1) begin
         @(negedge clk_i);
      end
      op_type_i   = op;
      reg_wb_en_i = wb_en;
      rd_label_i  = rd;
      alu_out_i   = alu;
      wb_sel_i    = sel;
      imm_i       = imm;
      pc_i        = pc;
      rs2_data_i  = rs2;
      in_valid_i  = 1'b1;
      load_val = load_expect(op, model_ram[idx], off);
      case (op)
         OP_SB:   model_ram[idx][8*off +: 8] = rs2[7:0];
         OP_SH:   model_ram[idx][8*off +: 16] = rs2[15:0];
         OP_SW:   model_ram[idx] = rs2;
         default: ;
      endcase
      case (sel)
         WB_ALU:  result = alu;
         WB_LOAD: result = load_val;
         WB_PC4:  result = pc + 32'd4;
         default: result = imm;
      endcase
      // x0 and disabled writes leave no trace
      if (wb_en && rd != 5'd0) begin
         exp_name_q.push_back(test_name);
         exp_rd_q.push_back(rd);
         exp_data_q.push_back(result);
      end
   endtask

   task automatic random_instr(input logic quiet);
      logic [31:0] r;
      lsu_op_e     op;
      wb_sel_e     sel;
      logic        wb_en;
      logic [4:0]  rd;
      logic [31:0] alu;
      logic [31:0] imm;
      logic [31:0] pc;
      logic [31:0] rs2;
      r     = $random(seed);
      alu   = $random(seed);
      imm   = $random(seed);
      pc    = $random(seed) & ~32'd3;
      rs2   = $random(seed);
      rd    = r[20:16];
      wb_en = 1'b1;
      if (r[2:0] < 3'd2) begin
         op = OP_NONE;
         case (r[11:10])
            2'd1:    sel = WB_PC4;
            2'd2:    sel = WB_IMM;
            default: sel = WB_ALU;
         endcase
      end else if (r[2:0] < 3'd5) begin
         op  = pick_load(int'(r[6:4]) % 5);
         sel = WB_LOAD;
         alu = aligned_addr(op, alu);
      end else begin
         case (r[9:8])
            2'd0:    op = OP_SB;
            2'd1:    op = OP_SH;
            default: op = OP_SW;
         endcase
         sel   = WB_ALU;
         wb_en = 1'b0;
         alu   = aligned_addr(op, alu);
      end
      if (quiet) begin
         if (r[21]) begin
            rd = 5'd0;
         end else begin
            wb_en = 1'b0;
         end
      end
      maybe_idle();
      send(op, wb_en, rd, alu, sel, imm, pc, rs2);
   endtask

   initial begin : main
      lsu_op_e     op;
      logic [31:0] addr;
      rst_i       = 1'b1;
      in_valid_i  = 1'b0;
      op_type_i   = OP_NONE;
      reg_wb_en_i = 1'b0;
      rd_label_i  = 5'd0;
      alu_out_i   = 32'd0;
      wb_sel_i    = WB_ALU;
      imm_i       = 32'd0;
      pc_i        = 32'd0;
      rs2_data_i  = 32'd0;
      repeat (RST_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      // Known RAM contents first
      test_name = "fill_sw";
      for (int i = 0; i < N_FILL; i++) begin
         send(OP_SW, 1'b0, 5'd0, i * 4, WB_ALU, 32'd0, 32'd0, $random(seed));
      end

      test_name = "wb_select";
      for (int i = 0; i < N_SELECT; i++) begin
         maybe_idle();
         send(OP_NONE, 1'b1, 5'($random(seed)), $random(seed),
              (i % 3 == 0) ? WB_ALU : ((i % 3 == 1) ? WB_PC4 : WB_IMM),
              $random(seed), $random(seed) & ~32'd3, $random(seed));
      end

      // Partial store, then read the whole word back
      test_name = "store_readback";
      for (int i = 0; i < N_PAIRS; i++) begin
         case (i % 3)
            0:       op = OP_SB;
            1:       op = OP_SH;
            default: op = OP_SW;
         endcase
         addr = aligned_addr(op, $random(seed));
         send(op, 1'b0, 5'd0, addr, WB_ALU, 32'd0, 32'd0, $random(seed));
         maybe_idle();
         send(OP_LW, 1'b1, 5'd1 + 5'(i % 31), addr & ~32'd3, WB_LOAD, 32'd0, 32'd0, 32'd0);
      end

      test_name = "load_extend";
      for (int i = 0; i < N_LOAD; i++) begin
         op = pick_load(i % 5);
         maybe_idle();
         send(op, 1'b1, 5'($random(seed)), aligned_addr(op, $random(seed)), WB_LOAD,
              32'd0, 32'd0, 32'd0);
      end

      test_name = "no_write";
      for (int i = 0; i < N_QUIET; i++) begin
         random_instr(1'b1);
      end

      test_name = "mixed_traffic";
      for (int i = 0; i < N_MIXED; i++) begin
         random_instr(1'b0);
      end
      idle_cycle();

      while (exp_rd_q.size() != 0) begin
         @(negedge clk_i);
      end
      // Room for any stray write to show up
      repeat (8) @(negedge clk_i);

      if (in_ready_o === 1'b1) begin
         $display("** PASS **");
         $finish;
      end else begin
         $display("Memory stage still stalled after all register writes drained");
         $display("** FAIL **");
         $fatal(1, "memory stage did not return to ready");
      end
   end

   // Six cycles per instruction covers bus waits and idle gaps
   initial begin : watchdog
      #(N_TOTAL * 6 * CLK_PERIOD + RST_CYCLES * CLK_PERIOD);
      $display("Timeout: the instructions did not complete in the allowed time");
      $display("** FAIL **");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// ==== wb_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Wishbone classic bus, word addressed
interface wb_if;

   // Master to slave
   logic        cyc;
   logic        stb;
   logic        we;
   logic [29:0] adr;
   logic [3:0]  sel;
   logic [31:0] dat_m2s;

   // Slave to master
   logic        ack;
   logic [31:0] dat_s2m;

   modport master (
      output cyc, stb, we, adr, sel, dat_m2s,
      input  ack, dat_s2m
   );

   modport slave (
      input  cyc, stb, we, adr, sel, dat_m2s,
      output ack, dat_s2m
   );

endinterface

`default_nettype wire

// ==== writeback_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
   input  wire logic clk_i,
   input  wire logic rst_i,
   mw_if.sink        mw,
   output logic        rf_we_o,
   output logic [4:0]  rf_addr_o,
   output logic [31:0] rf_data_o
);
   import mem_wb_pkg::*;

   logic        valid_q;
   logic        wr_en_q;
   logic [4:0]  rd_q;
   logic [31:0] data_q;
   logic [31:0] result;

   // Result select ahead of the register
   always_comb begin
      case (mw.wb_sel)
         WB_ALU:  result = mw.alu_out;
         WB_LOAD: result = mw.load_val;
         WB_PC4:  result = mw.pc + 32'd4;
         WB_IMM:  result = mw.imm;
         default: result = mw.alu_out;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= mw.valid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (mw.valid) begin
         wr_en_q <= mw.reg_wb_en;
         rd_q    <= mw.rd_label;
         data_q  <= result;
      end
   end

   // x0 is hardwired, never written
   assign rf_we_o   = valid_q && wr_en_q && (rd_q != 5'd0);
   assign rf_addr_o = rd_q;
   assign rf_data_o = data_q;

endmodule

`default_nettype wire
